// File: hw/sldu_op_pkg.sv
// SLDU operation encodings
// Opcode, element width and group multiplier codes as they arrive
// on the 3-bit inputs of the slide unit.

`default_nettype none

package sldu_op_pkg;

    // codes 6 and 7 run as op_none
    typedef enum logic [2:0] {
        op_none       = 3'd0,
        op_slide1up   = 3'd1,
        op_slideup    = 3'd2,
        op_slide1down = 3'd3,
        op_slidedown  = 3'd4,
        op_vmv        = 3'd5
    } sldu_op_e;

    // reserved codes run as e8
    typedef enum logic [2:0] {
        sew_e8  = 3'd0,
        sew_e16 = 3'd1,
        sew_e32 = 3'd2
    } sldu_sew_e;

    // reserved codes run as m1
    typedef enum logic [2:0] {
        lmul_m1 = 3'd0,
        lmul_m2 = 3'd1,
        lmul_m4 = 3'd2
    } sldu_lmul_e;

endpackage

`default_nettype wire

// File: hw/sldu_geom_pkg.sv
// SLDU byte-lane geometry
// Lane width, largest register group, offset width and the
// byte-count width that follows from the register length.

`default_nettype none

package sldu_geom_pkg;

    localparam int BYTE_W    = 8;  // bits per lane
    localparam int MAX_GROUP = 4;  // registers in an m4 group
    localparam int OFFSET_W  = 7;  // offset bits taken from rs1

    typedef logic [OFFSET_W-1:0] offset_t;
    typedef logic [BYTE_W-1:0]   byte_t;

    // width of a byte count up to and including a full m4 group
    function automatic int cnt_w(input int vlen);
        return $clog2(MAX_GROUP * vlen / BYTE_W) + 1;
    endfunction

endpackage

`default_nettype wire

// File: hw/sldu_decode.sv
// SLDU decode stage
// Resolves opcode, element width and group multiplier into byte-lane
// controls (element bytes, group bytes, shift in bytes, overrange flag)
// and registers them with the scalar and the vector operands.

`default_nettype none

module sldu_decode #(
    parameter int  VLEN  = 128,
    parameter int  XLEN  = 32,
    localparam int GRP_W = sldu_geom_pkg::MAX_GROUP * VLEN,
    localparam int CNT_W = sldu_geom_pkg::cnt_w(VLEN)
) (
    input  wire logic             clk,
    input  wire logic             nrst,
    input  wire logic [2:0]       op,
    input  wire logic [2:0]       sew,
    input  wire logic [2:0]       lmul,
    input  wire logic [XLEN-1:0]  rs1,
    input  wire logic [GRP_W-1:0] vs2,
    input  wire logic [GRP_W-1:0] vd,
    output logic                  s1_valid,
    output logic [2:0]            s1_op,
    output logic [CNT_W-1:0]      s1_elem_bytes,
    output logic [CNT_W-1:0]      s1_group_bytes,
    output logic [CNT_W-1:0]      s1_shift_bytes,
    output logic                  s1_over,
    output logic [XLEN-1:0]       s1_scalar,
    output logic [GRP_W-1:0]      s1_vs2,
    output logic [GRP_W-1:0]      s1_vd
);

    localparam int VLENB = VLEN / sldu_geom_pkg::BYTE_W;

    sldu_op_pkg::sldu_op_e              op_d;
    logic [1:0]                         sew_sh;  // log2 element bytes
    logic [1:0]                         grp_sh;  // log2 registers in group
    logic [CNT_W-1:0]                   elem_bytes;
    logic [CNT_W-1:0]                   group_bytes;
    logic [CNT_W-1:0]                   elem_cnt;
    sldu_geom_pkg::offset_t             k;
    logic [sldu_geom_pkg::OFFSET_W+1:0] shift_full;
    logic                               over;
    logic [XLEN-1:0]                    scalar;

    always_comb begin
        if (op > 3'(sldu_op_pkg::op_vmv))
            op_d = sldu_op_pkg::op_none;  // 6 and 7 idle
        else
            op_d = sldu_op_pkg::sldu_op_e'(op);
    end

    always_comb begin
        case (sldu_op_pkg::sldu_sew_e'(sew))
            sldu_op_pkg::sew_e16: sew_sh = 2'd1;
            sldu_op_pkg::sew_e32: sew_sh = 2'd2;
            default:              sew_sh = 2'd0;
        endcase
        case (sldu_op_pkg::sldu_lmul_e'(lmul))
            sldu_op_pkg::lmul_m2: grp_sh = 2'd1;
            sldu_op_pkg::lmul_m4: grp_sh = 2'd2;
            default:              grp_sh = 2'd0;
        endcase
    end

    assign elem_bytes  = CNT_W'(1) << sew_sh;
    assign group_bytes = CNT_W'(VLENB) << grp_sh;
    assign elem_cnt    = group_bytes >> sew_sh;

    // slide amount in elements
    always_comb begin
        case (op_d)
            sldu_op_pkg::op_slide1up,
            sldu_op_pkg::op_slide1down: k = sldu_geom_pkg::offset_t'(1);
            sldu_op_pkg::op_slideup,
            sldu_op_pkg::op_slidedown:  k = rs1[sldu_geom_pkg::OFFSET_W-1:0];
            default:                    k = '0;
        endcase
    end

    assign over       = (k >= elem_cnt);  // slid fully out of the group
    assign shift_full = {2'b00, k} << sew_sh;
    assign scalar     = rs1 & ~({XLEN{1'b1}} << (sldu_geom_pkg::BYTE_W << sew_sh));

    always_ff @(posedge clk) begin
        if (!nrst)
            s1_valid <= 1'b0;
        else
            s1_valid <= (op_d != sldu_op_pkg::op_none);
    end

    always_ff @(posedge clk) begin
        s1_op          <= op_d;
        s1_elem_bytes  <= elem_bytes;
        s1_group_bytes <= group_bytes;
        s1_shift_bytes <= over ? '0 : CNT_W'(shift_full);
        s1_over        <= over;
        s1_scalar      <= scalar;
        s1_vs2         <= vs2;
        s1_vd          <= vd;
    end

    // an in-range shift never reaches past the group
    a_shift_in_group: assert property (@(posedge clk) disable iff (!nrst)
        (s1_valid && !s1_over) |-> (s1_shift_bytes < s1_group_bytes));

endmodule

`default_nettype wire

// File: hw/sldu_slide_net.sv
// SLDU slide network
// Each byte lane of the result picks a shifted vs2 byte, the old vd
// byte, a scalar byte or zero. Lanes above the active group are zero.
// The lane results are registered and done pulses once per item.

`default_nettype none

module sldu_slide_net #(
    parameter int  VLEN  = 128,
    parameter int  XLEN  = 32,
    localparam int GRP_W = sldu_geom_pkg::MAX_GROUP * VLEN,
    localparam int CNT_W = sldu_geom_pkg::cnt_w(VLEN)
) (
    input  wire logic             clk,
    input  wire logic             nrst,
    input  wire logic             s1_valid,
    input  wire logic [2:0]       s1_op,
    input  wire logic [CNT_W-1:0] s1_elem_bytes,
    input  wire logic [CNT_W-1:0] s1_group_bytes,
    input  wire logic [CNT_W-1:0] s1_shift_bytes,
    input  wire logic             s1_over,
    input  wire logic [XLEN-1:0]  s1_scalar,
    input  wire logic [GRP_W-1:0] s1_vs2,
    input  wire logic [GRP_W-1:0] s1_vd,
    output logic [GRP_W-1:0]      result,
    output logic                  done
);

    localparam int BW    = sldu_geom_pkg::BYTE_W;
    localparam int TOT_B = GRP_W / BW;
    localparam int IDX_W = $clog2(TOT_B);
    localparam int SC_B  = XLEN / BW;
    localparam int SC_IW = $clog2(SC_B);

    sldu_geom_pkg::byte_t src_b [TOT_B];
    sldu_geom_pkg::byte_t vd_b  [TOT_B];
    sldu_geom_pkg::byte_t sc_b  [SC_B];
    logic [GRP_W-1:0]     res_d;

    for (genvar s = 0; s < SC_B; s++) begin : g_scalar
        assign sc_b[s] = s1_scalar[s*BW +: BW];
    end

    for (genvar b = 0; b < TOT_B; b++) begin : g_lane
        localparam logic [CNT_W-1:0] POS = CNT_W'(b);

        logic [CNT_W-1:0]     up_i;   // source lane on slide up
        logic [CNT_W-1:0]     dn_i;   // source lane on slide down
        logic [CNT_W-1:0]     top_i;  // byte within the top element
        sldu_geom_pkg::byte_t lane;

        assign src_b[b] = s1_vs2[b*BW +: BW];
        assign vd_b[b]  = s1_vd[b*BW +: BW];
        assign up_i     = POS - s1_shift_bytes;
        assign dn_i     = POS + s1_shift_bytes;
        assign top_i    = POS + s1_elem_bytes - s1_group_bytes;

        always_comb begin
            lane = '0;
            if (POS < s1_group_bytes) begin
                case (sldu_op_pkg::sldu_op_e'(s1_op))
                    sldu_op_pkg::op_slideup: begin
                        if (s1_over || POS < s1_shift_bytes)
                            lane = vd_b[b];  // below the offset
                        else
                            lane = src_b[up_i[IDX_W-1:0]];
                    end
                    sldu_op_pkg::op_slide1up: begin
                        if (POS < s1_shift_bytes)
                            lane = sc_b[SC_IW'(b)];
                        else
                            lane = src_b[up_i[IDX_W-1:0]];
                    end
                    sldu_op_pkg::op_slidedown: begin
                        if (!s1_over && dn_i < s1_group_bytes)
                            lane = src_b[dn_i[IDX_W-1:0]];
                    end
                    sldu_op_pkg::op_slide1down: begin
                        if (POS + s1_elem_bytes >= s1_group_bytes)
                            lane = sc_b[top_i[SC_IW-1:0]];  // top element
                        else
                            lane = src_b[dn_i[IDX_W-1:0]];
                    end
                    sldu_op_pkg::op_vmv: begin
                        if (POS < s1_elem_bytes)
                            lane = sc_b[SC_IW'(b)];
                    end
                    default: lane = '0;
                endcase
            end
        end

        assign res_d[b*BW +: BW] = lane;
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            result <= '0;
            done   <= 1'b0;
        end else begin
            done <= s1_valid;
            if (s1_valid)
                result <= res_d;  // idle cycles hold the last result
        end
    end

    // shifts move whole elements
    a_shift_whole_elems: assert property (@(posedge clk) disable iff (!nrst)
        s1_valid |-> ((s1_shift_bytes & (s1_elem_bytes - CNT_W'(1))) == '0));

endmodule

`default_nettype wire

// File: hw/sldu_top.sv
// SLDU top level
// Vector slide unit for the vector coprocessor: a decode stage
// followed by the byte-lane slide network, two cycles from operands
// to result. A new operation may enter every cycle.

`default_nettype none

module sldu_top #(
    parameter int  VLEN  = 128,
    parameter int  XLEN  = 32,
    localparam int GRP_W = sldu_geom_pkg::MAX_GROUP * VLEN,
    localparam int CNT_W = sldu_geom_pkg::cnt_w(VLEN)
) (
    input  wire logic             clk,
    input  wire logic             nrst,
    input  wire logic [2:0]       op,
    input  wire logic [2:0]       sew,
    input  wire logic [2:0]       lmul,
    input  wire logic [GRP_W-1:0] vs2,
    input  wire logic [GRP_W-1:0] vd,
    input  wire logic [XLEN-1:0]  rs1,
    output logic [GRP_W-1:0]      result,
    output logic                  done
);

    logic             s1_valid;
    logic [2:0]       s1_op;
    logic [CNT_W-1:0] s1_elem_bytes;
    logic [CNT_W-1:0] s1_group_bytes;
    logic [CNT_W-1:0] s1_shift_bytes;
    logic             s1_over;
    logic [XLEN-1:0]  s1_scalar;
    logic [GRP_W-1:0] s1_vs2;
    logic [GRP_W-1:0] s1_vd;

    sldu_decode #(
        .VLEN(VLEN),
        .XLEN(XLEN)
    ) sldu_decode_i (
        .clk           (clk),
        .nrst          (nrst),
        .op            (op),
        .sew           (sew),
        .lmul          (lmul),
        .rs1           (rs1),
        .vs2           (vs2),
        .vd            (vd),
        .s1_valid      (s1_valid),
        .s1_op         (s1_op),
        .s1_elem_bytes (s1_elem_bytes),
        .s1_group_bytes(s1_group_bytes),
        .s1_shift_bytes(s1_shift_bytes),
        .s1_over       (s1_over),
        .s1_scalar     (s1_scalar),
        .s1_vs2        (s1_vs2),
        .s1_vd         (s1_vd)
    );

    sldu_slide_net #(
        .VLEN(VLEN),
        .XLEN(XLEN)
    ) sldu_slide_net_i (
        .clk           (clk),
        .nrst          (nrst),
        .s1_valid      (s1_valid),
        .s1_op         (s1_op),
        .s1_elem_bytes (s1_elem_bytes),
        .s1_group_bytes(s1_group_bytes),
        .s1_shift_bytes(s1_shift_bytes),
        .s1_over       (s1_over),
        .s1_scalar     (s1_scalar),
        .s1_vs2        (s1_vs2),
        .s1_vd         (s1_vd),
        .result        (result),
        .done          (done)
    );

endmodule

`default_nettype wire

// File: sim/sldu_model.svh
// SLDU reference model
// Element-level model of the five slide operations for a 128-bit
// register length. Bytes above the active group come back as zero.

`ifndef SLDU_MODEL_SVH
`define SLDU_MODEL_SVH

localparam int SLDU_MDL_VLEN = 128;
localparam int SLDU_MDL_W    = sldu_geom_pkg::MAX_GROUP * SLDU_MDL_VLEN;

// element i of eb bytes, zero extended
function automatic logic [31:0] sldu_mdl_get(input logic [SLDU_MDL_W-1:0] v,
                                             input int i, input int eb);
    logic [31:0] e;
    e = '0;
    for (int j = 0; j < eb; j++) begin
        e[j*8 +: 8] = v[(i*eb + j)*8 +: 8];
    end
    return e;
endfunction

function automatic logic [SLDU_MDL_W-1:0] sldu_mdl_put(input logic [SLDU_MDL_W-1:0] v,
                                                       input int i, input int eb,
                                                       input logic [31:0] e);
    logic [SLDU_MDL_W-1:0] r;
    r = v;
    for (int j = 0; j < eb; j++) begin
        r[(i*eb + j)*8 +: 8] = e[j*8 +: 8];
    end
    return r;
endfunction

function automatic logic [SLDU_MDL_W-1:0] sldu_model(input logic [2:0] op,
                                                     input logic [2:0] sew,
                                                     input logic [2:0] lmul,
                                                     input logic [SLDU_MDL_W-1:0] vs2,
                                                     input logic [SLDU_MDL_W-1:0] vd,
                                                     input logic [31:0] rs1);
    int eb;
    int regs;
    int n;
    int k;
    logic [31:0] sc;
    logic [31:0] e;
    logic [SLDU_MDL_W-1:0] r;
    eb   = (sew == 3'd1) ? 2 : (sew == 3'd2) ? 4 : 1;
    regs = (lmul == 3'd1) ? 2 : (lmul == 3'd2) ? 4 : 1;
    n    = regs * SLDU_MDL_VLEN / 8 / eb;
    k    = int'(rs1[sldu_geom_pkg::OFFSET_W-1:0]);
    sc   = rs1 & (32'hffff_ffff >> (32 - 8*eb));
    r    = '0;
    for (int i = 0; i < n; i++) begin
        case (op)
            sldu_op_pkg::op_slideup:    e = (i < k) ? sldu_mdl_get(vd, i, eb)
                                                    : sldu_mdl_get(vs2, i - k, eb);
            sldu_op_pkg::op_slidedown:  e = (i + k < n) ? sldu_mdl_get(vs2, i + k, eb) : '0;
            sldu_op_pkg::op_slide1up:   e = (i == 0) ? sc : sldu_mdl_get(vs2, i - 1, eb);
            sldu_op_pkg::op_slide1down: e = (i == n - 1) ? sc : sldu_mdl_get(vs2, i + 1, eb);
            sldu_op_pkg::op_vmv:        e = (i == 0) ? sc : '0;
            default:                    e = '0;
        endcase
        r = sldu_mdl_put(r, i, eb, e);
    end
    return r;
endfunction

`endif

// File: sim/sldu_tb.sv
// SLDU testbench
// Applies a table of slide operations back to back on random vector
// operands and checks each result against the element-level model,
// along with the done pulse timing, result hold on idle rows and reset.

`default_nettype none

module sldu_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int  VLEN   = 128;
    localparam int  XLEN   = 32;
    localparam int  GRP_W  = sldu_geom_pkg::MAX_GROUP * VLEN;
    localparam time PERIOD = 20ns;

    `include "sldu_model.svh"

    logic             clk;
    logic             nrst;
    logic [2:0]       op;
    logic [2:0]       sew;
    logic [2:0]       lmul;
    logic [GRP_W-1:0] vs2;
    logic [GRP_W-1:0] vd;
    logic [XLEN-1:0]  rs1;
    logic [GRP_W-1:0] result;
    logic             done;

    int               seed;
    int               value_errors;
    int               other_errors;
    int               cycle_count;
    int               cycle_limit;
    bit               checking;
    logic [GRP_W-1:0] last_result;

    // stimulus table
    string       row_name [$];
    logic [2:0]  row_op   [$];
    logic [2:0]  row_sew  [$];
    logic [2:0]  row_lmul [$];
    logic [31:0] row_rs1  [$];

    // operations in flight
    string            name_q [$];
    logic [GRP_W-1:0] exp_q  [$];
    time              due_q  [$];

    sldu_top #(
        .VLEN(VLEN),
        .XLEN(XLEN)
    ) sldu_top_i (
        .clk   (clk),
        .nrst  (nrst),
        .op    (op),
        .sew   (sew),
        .lmul  (lmul),
        .vs2   (vs2),
        .vd    (vd),
        .rs1   (rs1),
        .result(result),
        .done  (done)
    );

    always #(PERIOD / 2) clk = ~clk;

    task automatic add_row(input string name, input logic [2:0] o, input logic [2:0] s,
                           input logic [2:0] l, input logic [31:0] a);
        row_name.push_back(name);
        row_op.push_back(o);
        row_sew.push_back(s);
        row_lmul.push_back(l);
        row_rs1.push_back(a);
    endtask

    function automatic logic [GRP_W-1:0] random_vector();
        logic [GRP_W-1:0] v;
        for (int w = 0; w < GRP_W / 32; w++) begin
            v[w*32 +: 32] = $random(seed);
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [GRP_W-1:0] expected,
                               input logic [GRP_W-1:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic apply_row(input int r);
        vs2  = random_vector();
        vd   = random_vector();
        op   = row_op[r];
        sew  = row_sew[r];
        lmul = row_lmul[r];
        rs1  = row_rs1[r];
        if (row_op[r] >= 3'd1 && row_op[r] <= 3'd5) begin  // idle codes give no done
            exp_q.push_back(sldu_model(row_op[r], row_sew[r], row_lmul[r], vs2, vd, row_rs1[r]));
            name_q.push_back(row_name[r]);
            due_q.push_back($time + 2 * PERIOD);
        end
    endtask

    task automatic build_table();
        add_row("up_e8_m1_k0",      sldu_op_pkg::op_slideup,    3'd0, 3'd0, 32'd0);
        add_row("up_e8_m1_k5",      sldu_op_pkg::op_slideup,    3'd0, 3'd0, 32'd5);
        add_row("up_e8_m1_k16",     sldu_op_pkg::op_slideup,    3'd0, 3'd0, 32'd16);
        add_row("up_e16_m2_k3",     sldu_op_pkg::op_slideup,    3'd1, 3'd1, 32'd3);
        add_row("up_e16_m2_k16",    sldu_op_pkg::op_slideup,    3'd1, 3'd1, 32'd16);
        add_row("up_e32_m4_k7",     sldu_op_pkg::op_slideup,    3'd2, 3'd2, 32'd7);
        add_row("up_e32_m4_k100",   sldu_op_pkg::op_slideup,    3'd2, 3'd2, 32'd100);
        add_row("up_e32_m1_k0",     sldu_op_pkg::op_slideup,    3'd2, 3'd0, 32'd0);
        add_row("dn_e8_m1_k3",      sldu_op_pkg::op_slidedown,  3'd0, 3'd0, 32'd3);
        add_row("dn_e16_m1_k8",     sldu_op_pkg::op_slidedown,  3'd1, 3'd0, 32'd8);
        add_row("dn_e16_m2_k5",     sldu_op_pkg::op_slidedown,  3'd1, 3'd1, 32'd5);
        add_row("dn_e32_m4_k15",    sldu_op_pkg::op_slidedown,  3'd2, 3'd2, 32'd15);
        add_row("dn_e8_m4_k64",     sldu_op_pkg::op_slidedown,  3'd0, 3'd2, 32'd64);
        add_row("dn_e32_m2_k0",     sldu_op_pkg::op_slidedown,  3'd2, 3'd1, 32'd0);
        add_row("s1up_e8_m1",       sldu_op_pkg::op_slide1up,   3'd0, 3'd0, 32'hdead_beef);
        add_row("s1up_e16_m2",      sldu_op_pkg::op_slide1up,   3'd1, 3'd1, 32'h1234_5678);
        add_row("s1up_e32_m4",      sldu_op_pkg::op_slide1up,   3'd2, 3'd2, 32'h8765_4321);
        add_row("s1dn_e8_m4",       sldu_op_pkg::op_slide1down, 3'd0, 3'd2, 32'hcafe_f00d);
        add_row("s1dn_e16_m1",      sldu_op_pkg::op_slide1down, 3'd1, 3'd0, 32'h0bad_c0de);
        add_row("s1dn_e32_m2",      sldu_op_pkg::op_slide1down, 3'd2, 3'd1, 32'hfeed_5eed);
        add_row("vmv_e8_m1",        sldu_op_pkg::op_vmv,        3'd0, 3'd0, 32'h0000_01a5);
        add_row("none_row",         sldu_op_pkg::op_none,       3'd0, 3'd0, 32'd9);
        add_row("vmv_e16_m2",       sldu_op_pkg::op_vmv,        3'd1, 3'd1, 32'h7777_abcd);
        add_row("code6_row",        3'd6,                       3'd2, 3'd2, 32'd1);
        add_row("vmv_e32_m4",       sldu_op_pkg::op_vmv,        3'd2, 3'd2, 32'h9abc_def0);
        add_row("rsv_sew_lmul_up",  sldu_op_pkg::op_slideup,    3'd5, 3'd3, 32'd2);
    endtask

    // result and done are stable mid-cycle
    always @(negedge clk) begin
        if (checking) begin
            if (done) begin
                if (exp_q.size() == 0) begin
                    $display("extra done pulse with no operation in flight at %0t", $time);
                    other_errors++;
                end else begin
                    if (due_q[0] != $time) begin
                        $display("done for %s came at %0t but was due at %0t",
                                 name_q[0], $time, due_q[0]);
                        other_errors++;
                    end
                    check_value(name_q[0], exp_q[0], result);
                    last_result = exp_q[0];
                    void'(name_q.pop_front());
                    void'(exp_q.pop_front());
                    void'(due_q.pop_front());
                end
            end else begin
                check_value("hold", last_result, result);
                if (exp_q.size() != 0 && due_q[0] <= $time) begin
                    $display("no done pulse for %s, due at %0t", name_q[0], due_q[0]);
                    other_errors++;
                    void'(name_q.pop_front());
                    void'(exp_q.pop_front());
                    void'(due_q.pop_front());
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, %0d operations still pending",
                     cycle_count, exp_q.size());
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial begin
        seed         = 32'h2bc2_ef05;
        value_errors = 0;
        other_errors = 0;
        cycle_count  = 0;
        cycle_limit  = 1000;
        checking     = 1'b0;
        last_result  = '0;
        clk          = 1'b0;
        nrst         = 1'b0;
        op           = sldu_op_pkg::op_vmv;  // busy inputs while in reset
        sew          = '0;
        lmul         = '0;
        vs2          = '0;
        vd           = '0;
        rs1          = 32'h0000_00a5;

        build_table();
        cycle_limit = 8 + row_name.size() + 20;

        repeat (8) begin
            @(negedge clk);
            check_value("reset_done", '0, done);
            check_value("reset_result", '0, result);
        end
        op   = sldu_op_pkg::op_none;
        rs1  = '0;
        nrst = 1'b1;
        @(posedge clk);
        checking = 1'b1;  // monitor covers the first idle cycles too

        for (int r = 0; r < row_name.size(); r++) begin
            @(negedge clk);
            apply_row(r);
        end
        @(negedge clk);
        op = sldu_op_pkg::op_none;
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk);  // catch stray done pulses

        $display("errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+sim
hw/sldu_op_pkg.sv
hw/sldu_geom_pkg.sv
hw/sldu_decode.sv
hw/sldu_slide_net.sv
hw/sldu_top.sv
sim/sldu_tb.sv
